//--- run.sh
#!/bin/sh
# Build the FMA unit testbench with Verilator and run it.
# The exit status of the simulation binary is the exit status of this script.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f sim.f \
    --top-module fpu_fma_tb \
    -o sim_fpu_fma

./obj_dir/sim_fpu_fma

//--- sim.f
+incdir+verilog
verilog/fpu_pkg.sv
verilog/lane_stream_if.sv
verilog/fma_pe.sv
verilog/fma_operand_select.sv
verilog/pe_serializer.sv
verilog/fflags_merge.sv
verilog/fpu_fma.sv
verif/tb_clock.sv
verif/fpu_fma_tb.sv

//--- verif/fpu_fma_tb.sv
/*
 * Directed testbench of the FMA unit: fp32 reference model in double
 * precision, Galois LFSR stimulus, response monitor and watchdog
 */
`timescale 1ns/1ps
`include "fpu_defs.svh"

module fpu_fma_tb;
    import fpu_pkg::*;

    typedef logic [`FMA_NUM_LANES-1:0][31:0] lanes_t;

    typedef struct packed {
        lanes_t                    value;
        fflags_t                   flags;
        logic [`FMA_TAG_WIDTH-1:0] tag;
    } expect_t;

    // Operation bits as {is_madd, is_sub, is_neg}
    localparam logic [2:0] OP_ADD   = 3'b000;
    localparam logic [2:0] OP_SUB   = 3'b010;
    localparam logic [2:0] OP_MUL   = 3'b001;
    localparam logic [2:0] OP_MADD  = 3'b100;
    localparam logic [2:0] OP_MSUB  = 3'b110;
    localparam logic [2:0] OP_NMADD = 3'b101;
    localparam logic [2:0] OP_NMSUB = 3'b111;

    localparam int BP_REQS     = 30;
    localparam int TOTAL_REQS  = 12 + BP_REQS;
    localparam int WATCHDOG_NS = 20 * TOTAL_REQS * 50;

    logic                            clk;
    logic                            reset;
    logic                            valid_in;
    logic                            ready_in;
    logic [`FMA_NUM_LANES-1:0]       mask_in;
    logic [`FMA_TAG_WIDTH-1:0]       tag_in;
    logic                            is_madd;
    logic                            is_sub;
    logic                            is_neg;
    lanes_t                          dataa;
    lanes_t                          datab;
    lanes_t                          datac;
    logic                            valid_out;
    logic                            ready_out;
    lanes_t                          result;
    fflags_t                         fflags;
    logic [`FMA_TAG_WIDTH-1:0]       tag_out;

    logic [31:0] lfsr_state;
    expect_t     exp_q [$];
    logic        bp_done;

    tb_clock tb_clock_i (
        .clk   (clk),
        .reset (reset)
    );

    fpu_fma fpu_fma_i (
        .clk       (clk),
        .reset     (reset),
        .valid_in  (valid_in),
        .ready_in  (ready_in),
        .mask_in   (mask_in),
        .tag_in    (tag_in),
        .is_madd   (is_madd),
        .is_sub    (is_sub),
        .is_neg    (is_neg),
        .dataa     (dataa),
        .datab     (datab),
        .datac     (datac),
        .valid_out (valid_out),
        .ready_out (ready_out),
        .result    (result),
        .fflags    (fflags),
        .tag_out   (tag_out)
    );

    task automatic report_error(input string msg);
        $display("error at %0t ns: %s", $time, msg);
        $display("Simulation failed");
        $fatal(1, "stopped at the first error");
    endtask

    // Galois LFSR, one step per bit taken
    function automatic logic lfsr_bit();
        logic b;
        b = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (b) begin
            lfsr_state = lfsr_state ^ 32'h8020_0003;
        end
        return b;
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_bit()};
        end
        return r;
    endfunction

    // Finite fp32 to double, flushing subnormals to signed zero
    function automatic real f2d(input logic [31:0] f);
        logic [10:0] e;
        if (f[30:23] == 8'd0) begin
            return $bitstoreal({f[31], 63'd0});
        end
        e = {3'b000, f[30:23]} + 11'd896;
        return $bitstoreal({f[31], e, f[22:0], 29'd0});
    endfunction

    // Double to fp32, only for values that fit 24 bits exactly
    function automatic logic [31:0] d2f(input real r);
        logic [63:0] bits;
        logic [10:0] e;
        bits = $realtobits(r);
        if (bits[62:0] == 63'd0) begin
            return {bits[63], 31'd0};
        end
        e = bits[62:52] - 11'd896;
        return {bits[63], e[7:0], bits[51:29]};
    endfunction

    function automatic logic [31:0] i2f(input int v);
        return d2f($itor(v));
    endfunction

    function automatic lanes_t lanes4(input logic [31:0] l0, l1, l2, l3);
        return {l3, l2, l1, l0};
    endfunction

    function automatic lanes_t ints4(input int v0, v1, v2, v3);
        return lanes4(i2f(v0), i2f(v1), i2f(v2), i2f(v3));
    endfunction

    // Small halves in -4.0 .. 3.5
    function automatic logic [31:0] rand_operand();
        logic [3:0] v;
        int         iv;
        v  = 4'(random_bits(4));
        iv = int'($signed(v));
        return d2f($itor(iv) / 2.0);
    endfunction

    // Exact a*b+c per lane after the operation mapping of the spec
    function automatic lanes_t fma_model(input logic [2:0] op, input lanes_t a, b, c);
        lanes_t r;
        real    ra, rb, rc, v;
        for (int i = 0; i < `FMA_NUM_LANES; i++) begin
            ra = f2d(a[i]);
            rb = f2d(b[i]);
            rc = f2d(c[i]);
            if (op[2]) begin
                v = (op[0] ? -ra : ra) * rb + ((op[0] ^ op[1]) ? -rc : rc);
            end else if (op[0]) begin
                v = ra * rb + 0.0;
            end else begin
                v = ra * 1.0 + (op[1] ? -rb : rb);
            end
            r[i] = d2f(v);
        end
        return r;
    endfunction

    task automatic send_req(input logic [3:0] mask, input logic [3:0] tag,
                            input logic [2:0] op, input lanes_t a, b, c,
                            input lanes_t exp_value, input fflags_t exp_flags);
        valid_in = 1'b1;
        mask_in  = mask;
        tag_in   = tag;
        {is_madd, is_sub, is_neg} = op;
        dataa = a;
        datab = b;
        datac = c;
        while (!ready_in) begin
            @(posedge clk);
            #1;
        end
        exp_q.push_back('{value: exp_value, flags: exp_flags, tag: tag});
        @(posedge clk);
        #1;
        valid_in = 1'b0;
    endtask

    task automatic send_exact(input logic [3:0] mask, input logic [3:0] tag,
                              input logic [2:0] op, input lanes_t a, b, c);
        send_req(mask, tag, op, a, b, c, fma_model(op, a, b, c), '0);
    endtask

    task automatic wait_drain();
        do begin
            @(posedge clk);
        end while (exp_q.size() != 0);
        #1;
    endtask

    task automatic check_response();
        expect_t e;
        assert (exp_q.size() != 0)
        else report_error("a response arrived with no request outstanding");
        e = exp_q.pop_front();
        for (int i = 0; i < `FMA_NUM_LANES; i++) begin
            assert (result[i] === e.value[i])
            else report_error($sformatf("tag %h lane %0d result %h, expected %h",
                                        e.tag, i, result[i], e.value[i]));
        end
        assert (fflags === e.flags)
        else report_error($sformatf("tag %h fflags %b, expected %b", e.tag, fflags, e.flags));
        assert (tag_out === e.tag)
        else report_error($sformatf("tag_out %h, expected %h", tag_out, e.tag));
    endtask

    // Outputs are stable at the falling edge
    initial begin
        forever begin
            @(negedge clk);
            if (!reset && valid_out && ready_out) begin
                check_response();
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Simulation failed");
        $fatal(1, "timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
    end

    task automatic test_add_sub();
        assert (valid_out === 1'b0) else report_error("valid_out is high right after reset");
        assert (ready_in === 1'b1) else report_error("ready_in is low right after reset");
        send_exact(4'hf, 4'h1, OP_ADD, ints4(1, 2, 3, -4), ints4(5, -6, 7, 8), '0);
        send_exact(4'hf, 4'h2, OP_SUB, lanes4(i2f(10), i2f(-3), d2f(0.5), i2f(7)),
                   lanes4(i2f(4), i2f(5), d2f(2.5), i2f(7)), '0);
        wait_drain();
    endtask

    task automatic test_mul_madd();
        logic [2:0] ops [5] = '{OP_MUL, OP_MADD, OP_MSUB, OP_NMADD, OP_NMSUB};
        // NMADD lane 0 is -(2*3+1)
        for (int i = 0; i < 5; i++) begin
            send_exact(4'hf, 4'(i + 3), ops[i], ints4(2, -3, 4, 1), ints4(3, 2, -1, 5),
                       ints4(1, 1, 2, -6));
        end
        wait_drain();
    endtask

    task automatic test_flags();
        lanes_t a;
        lanes_t b;
        lanes_t e;
        // inf*0 in lane 0, unmasked and then masked off
        a = lanes4(32'h7f80_0000, i2f(2), i2f(3), i2f(-1));
        b = lanes4(32'h0000_0000, i2f(3), i2f(2), i2f(4));
        e = fma_model(OP_MUL, a, b, '0);
        e[0] = 32'h7fc0_0000;
        send_req(4'hf, 4'h8, OP_MUL, a, b, '0, e, 5'b10000);
        send_req(4'he, 4'h9, OP_MUL, a, b, '0, e, 5'b00000);
        // About 3e38 times 10 in lane 1
        a = lanes4(i2f(1), 32'h7f61_b1e6, i2f(2), i2f(2));
        b = lanes4(i2f(1), 32'h4120_0000, i2f(2), i2f(-2));
        e = fma_model(OP_MUL, a, b, '0);
        e[1] = 32'h7f80_0000;
        send_req(4'hf, 4'ha, OP_MUL, a, b, '0, e, 5'b00101);
        // 1 + 2^-30 loses the small addend
        a = ints4(1, 1, 2, 3);
        b = lanes4(32'h3080_0000, i2f(1), i2f(2), i2f(3));
        e = fma_model(OP_ADD, a, b, '0);
        e[0] = 32'h3f80_0000;
        send_req(4'hf, 4'hb, OP_ADD, a, b, '0, e, 5'b00001);
        wait_drain();
    endtask

    // Half-ulp addend 2^-24 on top of values near 1.0
    task automatic test_round_even();
        lanes_t a;
        lanes_t b;
        lanes_t e;
        a = lanes4(32'h3f80_0000, 32'h3f80_0001, 32'h3f80_0003, i2f(2));
        b = lanes4(32'h3380_0000, 32'h3380_0000, 32'h3380_0000, i2f(2));
        e = lanes4(32'h3f80_0000, 32'h3f80_0002, 32'h3f80_0004, i2f(4));
        send_req(4'hf, 4'hc, OP_ADD, a, b, '0, e, 5'b00001);
        wait_drain();
    endtask

    task automatic test_backpressure();
        lanes_t     a_arr    [BP_REQS];
        lanes_t     b_arr    [BP_REQS];
        lanes_t     c_arr    [BP_REQS];
        logic [3:0] mask_arr [BP_REQS];
        logic [3:0] tag_arr  [BP_REQS];
        logic [2:0] op_arr   [BP_REQS];
        int         gap_arr  [BP_REQS];
        for (int i = 0; i < BP_REQS; i++) begin
            op_arr[i]   = 3'(random_bits(3));
            mask_arr[i] = 4'(random_bits(4));
            tag_arr[i]  = 4'(random_bits(4));
            gap_arr[i]  = int'(random_bits(2));
            for (int l = 0; l < `FMA_NUM_LANES; l++) begin
                a_arr[i][l] = rand_operand();
                b_arr[i][l] = rand_operand();
                c_arr[i][l] = rand_operand();
            end
        end
        bp_done = 1'b0;
        // Output stalls about one cycle in four
        fork
            begin
                while (!bp_done) begin
                    @(posedge clk);
                    #1;
                    if (!bp_done) begin
                        ready_out = lfsr_bit() | lfsr_bit();
                    end
                end
            end
        join_none
        for (int i = 0; i < BP_REQS; i++) begin
            for (int g = 0; g < gap_arr[i]; g++) begin
                @(posedge clk);
                #1;
            end
            send_exact(mask_arr[i], tag_arr[i], op_arr[i], a_arr[i], b_arr[i], c_arr[i]);
        end
        wait_drain();
        bp_done = 1'b1;
        ready_out = 1'b1;
        // Idle window, a duplicate response would find no request outstanding
        repeat (20) @(posedge clk);
        #1;
    endtask

    initial begin
        valid_in    = 1'b0;
        mask_in     = '0;
        tag_in      = '0;
        is_madd     = 1'b0;
        is_sub      = 1'b0;
        is_neg      = 1'b0;
        dataa       = '0;
        datab       = '0;
        datac       = '0;
        ready_out   = 1'b1;
        lfsr_state  = 32'h7c2a72f2;
        bp_done     = 1'b0;
        @(negedge reset);
        test_add_sub();
        test_mul_madd();
        test_flags();
        test_round_even();
        test_backpressure();
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

//--- verif/tb_clock.sv
/*
 * Testbench clock and reset: 10 ns clock period,
 * synchronous reset held high for the first 4 rising edges
 */
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic reset
);
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Release 1 ns after the fourth rising edge
    initial begin
        reset = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
    end

endmodule

//--- verilog/fflags_merge.sv
/*
 * Output side of the FMA unit: ORs the flags of active lanes and
 * registers result, flags and tag onto the output handshake
 */
`timescale 1ns/1ps
`include "fpu_defs.svh"

module fflags_merge (
    input  logic                            clk,
    input  logic                            reset,
    lane_stream_if.sink                     rsp_s,
    output logic                            valid_out,
    input  logic                            ready_out,
    output logic [`FMA_NUM_LANES-1:0][31:0] result,
    output fpu_pkg::fflags_t                fflags,
    output logic [`FMA_TAG_WIDTH-1:0]       tag_out
);
    import fpu_pkg::*;

    fflags_t merged;
    logic    load;

    // Masked-off lanes pass a result but no flags
    always_comb begin
        merged = '0;
        for (int i = 0; i < `FMA_NUM_LANES; i++) begin
            if (rsp_s.mask[i]) begin
                merged = merged | rsp_s.payload[i].flags;
            end
        end
    end

    assign rsp_s.ready = !valid_out || ready_out;
    assign load        = rsp_s.valid && rsp_s.ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_out <= 1'b0;
        end else if (rsp_s.ready) begin
            valid_out <= rsp_s.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            for (int i = 0; i < `FMA_NUM_LANES; i++) begin
                result[i] <= rsp_s.payload[i].value;
            end
            fflags  <= merged;
            tag_out <= rsp_s.tag;
        end
    end

    a_idle_after_reset: assert property (@(posedge clk) reset |=> !valid_out);

endmodule

//--- verilog/fma_operand_select.sv
/*
 * Input side of the FMA unit: maps the operation bits onto a*b+c
 * per lane and registers the request in a two-entry skid buffer
 */
`timescale 1ns/1ps
`include "fpu_defs.svh"

module fma_operand_select (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            valid_in,
    output logic                            ready_in,
    input  logic [`FMA_NUM_LANES-1:0]       mask_in,
    input  logic [`FMA_TAG_WIDTH-1:0]       tag_in,
    input  logic                            is_madd,
    input  logic                            is_sub,
    input  logic                            is_neg,
    input  logic [`FMA_NUM_LANES-1:0][31:0] dataa,
    input  logic [`FMA_NUM_LANES-1:0][31:0] datab,
    input  logic [`FMA_NUM_LANES-1:0][31:0] datac,
    lane_stream_if.source                   req_s
);
    import fpu_pkg::*;

    typedef struct packed {
        fma_req_t                  ops;
        logic [`FMA_NUM_LANES-1:0] mask;
        logic [`FMA_TAG_WIDTH-1:0] tag;
    } entry_t;

    entry_t in_entry;
    entry_t out_entry;
    entry_t skid_entry;
    logic   out_valid;
    logic   skid_valid;
    logic   accept;
    logic   out_fire;

    always_comb begin
        for (int i = 0; i < `FMA_NUM_LANES; i++) begin
            if (is_madd) begin
                // MADD, MSUB, NMADD, NMSUB
                in_entry.ops[i].a = {dataa[i][31] ^ is_neg, dataa[i][30:0]};
                in_entry.ops[i].b = datab[i];
                in_entry.ops[i].c = {datac[i][31] ^ is_neg ^ is_sub, datac[i][30:0]};
            end else if (is_neg) begin
                // MUL, addend is zero
                in_entry.ops[i].a = dataa[i];
                in_entry.ops[i].b = datab[i];
                in_entry.ops[i].c = 32'h0;
            end else begin
                // ADD and SUB go through a multiply by 1.0
                in_entry.ops[i].a = dataa[i];
                in_entry.ops[i].b = 32'h3f80_0000;
                in_entry.ops[i].c = {datab[i][31] ^ is_sub, datab[i][30:0]};
            end
        end
        in_entry.mask = mask_in;
        in_entry.tag  = tag_in;
    end

    // Skid entry only fills while the output entry is stalled
    assign ready_in = !skid_valid;
    assign accept   = valid_in && ready_in;
    assign out_fire = out_valid && req_s.ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
        end else begin
            if (!out_valid || out_fire) begin
                out_valid <= skid_valid || accept;
            end
            skid_valid <= (skid_valid || accept) && out_valid && !out_fire;
        end
    end

    always_ff @(posedge clk) begin
        if (!out_valid || out_fire) begin
            out_entry <= skid_valid ? skid_entry : in_entry;
        end
        if (accept) begin
            skid_entry <= in_entry;
        end
    end

    assign req_s.valid   = out_valid;
    assign req_s.payload = out_entry.ops;
    assign req_s.mask    = out_entry.mask;
    assign req_s.tag     = out_entry.tag;

    // Serializer may take several cycles, request must hold meanwhile
    a_req_stable: assert property (@(posedge clk) disable iff (reset)
        req_s.valid && !req_s.ready |=> req_s.valid && $stable(req_s.payload)
            && $stable(req_s.mask) && $stable(req_s.tag));

endmodule

//--- verilog/fma_pe.sv
/*
 * Single-lane fp32 fused multiply-add in three enabled stages:
 * unpack and multiply, align and add, normalize and round.
 * Nearest-even rounding, subnormals flushed, canonical NaN
 */
`timescale 1ns/1ps

module fma_pe (
    input  logic                   clk,
    input  logic                   enable,
    input  fpu_pkg::fma_operands_t operands,
    output fpu_pkg::lane_result_t  result
);
    import fpu_pkg::*;

    // Exponent given to zero operands so they never win alignment
    localparam logic signed [10:0] ZERO_EXP = -11'sd512;

    logic [7:0]         ea, eb, ec;
    logic               a_zero, b_zero, c_zero, a_inf, b_inf, c_inf;
    logic               a_nan, b_nan, c_nan;
    logic               ps, snan, inf_zero, prod_inf, inf_sub;
    logic [23:0]        ma, mb;
    logic signed [10:0] pexp_top;

    logic               s1_nan, s1_nv, s1_inf, s1_inf_sign, s1_ps, s1_sc;
    logic signed [10:0] s1_pexp, s1_cexp;
    logic [47:0]        s1_prod;
    logic [23:0]        s1_mc;

    assign ea = operands.a[30:23];
    assign eb = operands.b[30:23];
    assign ec = operands.c[30:23];
    // Subnormals count as zero
    assign a_zero = ea == 8'd0;
    assign b_zero = eb == 8'd0;
    assign c_zero = ec == 8'd0;
    assign a_inf  = ea == 8'hff && operands.a[22:0] == 23'd0;
    assign b_inf  = eb == 8'hff && operands.b[22:0] == 23'd0;
    assign c_inf  = ec == 8'hff && operands.c[22:0] == 23'd0;
    assign a_nan  = ea == 8'hff && operands.a[22:0] != 23'd0;
    assign b_nan  = eb == 8'hff && operands.b[22:0] != 23'd0;
    assign c_nan  = ec == 8'hff && operands.c[22:0] != 23'd0;

    assign ps       = operands.a[31] ^ operands.b[31];
    assign snan     = (a_nan && !operands.a[22]) || (b_nan && !operands.b[22])
                      || (c_nan && !operands.c[22]);
    assign inf_zero = (a_inf && b_zero) || (a_zero && b_inf);
    assign prod_inf = a_inf || b_inf;
    assign inf_sub  = prod_inf && c_inf && (ps != operands.c[31]);
    assign ma       = a_zero ? 24'd0 : {1'b1, operands.a[22:0]};
    assign mb       = b_zero ? 24'd0 : {1'b1, operands.b[22:0]};
    // Weight of product bit 47, one above the ea+eb-127 of bit 46
    assign pexp_top = $signed({3'b000, ea}) + $signed({3'b000, eb}) - 11'sd126;

    always_ff @(posedge clk) begin
        if (enable) begin
            s1_nan      <= a_nan || b_nan || c_nan || inf_zero || inf_sub;
            s1_nv       <= snan || inf_zero || inf_sub;
            s1_inf      <= prod_inf || c_inf;
            s1_inf_sign <= prod_inf ? ps : operands.c[31];
            s1_ps       <= ps;
            s1_sc       <= operands.c[31];
            s1_prod     <= 48'(ma) * 48'(mb);
            s1_pexp     <= (a_zero || b_zero) ? ZERO_EXP : pexp_top;
            s1_cexp     <= c_zero ? ZERO_EXP : $signed({3'b000, ec});
            s1_mc       <= c_zero ? 24'd0 : {1'b1, operands.c[22:0]};
        end
    end

    logic               prod_big, neg;
    logic signed [10:0] exp_diff;
    logic [5:0]         shamt;
    logic [47:0]        big_m, small_m;
    logic [99:0]        shifted;
    logic [51:0]        big_f, small_f;
    logic [52:0]        sum;

    logic               s2_nan, s2_nv, s2_inf, s2_inf_sign, s2_sign, s2_zero_sign;
    logic signed [10:0] s2_exp;
    logic [51:0]        s2_mag;

    // Field: carry, 48 value bits, 2 guard bits, sticky
    always_comb begin
        prod_big = s1_pexp >= s1_cexp;
        exp_diff = prod_big ? s1_pexp - s1_cexp : s1_cexp - s1_pexp;
        shamt    = (exp_diff > 11'sd63) ? 6'd63 : exp_diff[5:0];
        big_m    = prod_big ? s1_prod : {s1_mc, 24'd0};
        small_m  = prod_big ? {s1_mc, 24'd0} : s1_prod;
        shifted  = {small_m, 52'd0} >> shamt;
        big_f    = {1'b0, big_m, 3'b000};
        small_f  = {1'b0, shifted[99:50], |shifted[49:0]};
        sum      = (s1_ps ^ s1_sc) ? {1'b0, big_f} - {1'b0, small_f}
                                   : {1'b0, big_f} + {1'b0, small_f};
        neg      = sum[52];
    end

    always_ff @(posedge clk) begin
        if (enable) begin
            s2_nan       <= s1_nan;
            s2_nv        <= s1_nv;
            s2_inf       <= s1_inf;
            s2_inf_sign  <= s1_inf_sign;
            s2_sign      <= (prod_big ? s1_ps : s1_sc) ^ neg;
            s2_zero_sign <= s1_ps && s1_sc;
            s2_exp       <= prod_big ? s1_pexp : s1_cexp;
            s2_mag       <= neg ? -sum[51:0] : sum[51:0];
        end
    end

    int                 lead;
    logic [51:0]        norm;
    logic [24:0]        mant_r;
    logic               round_bit, sticky;
    logic signed [11:0] exp_r;
    fflags_t            flags;
    logic [31:0]        value;

    always_comb begin
        lead = 0;
        for (int k = 0; k < 52; k++) begin
            if (s2_mag[k]) begin
                lead = k;
            end
        end
        norm      = s2_mag << (51 - lead);
        round_bit = norm[27];
        sticky    = |norm[26:0];
        mant_r    = {1'b0, norm[51:28]} + 25'(round_bit && (sticky || norm[28]));
        // Field bit 50 carries the aligned exponent
        exp_r     = 12'(s2_exp) + 12'(lead - 50) + {11'd0, mant_r[24]};
        flags     = '0;
        if (s2_nan) begin
            value    = 32'h7fc0_0000;
            flags.nv = s2_nv;
        end else if (s2_inf) begin
            value = {s2_inf_sign, 8'hff, 23'd0};
        end else if (s2_mag == 52'd0) begin
            value = {s2_zero_sign, 31'd0};
        end else if (exp_r >= 12'sd255) begin
            value    = {s2_sign, 8'hff, 23'd0};
            flags.of = 1'b1;
            flags.nx = 1'b1;
        end else if (exp_r <= 12'sd0) begin
            value    = {s2_sign, 31'd0};
            flags.uf = 1'b1;
            flags.nx = 1'b1;
        end else begin
            // A rounding carry leaves the fraction all zero
            value    = {s2_sign, exp_r[7:0], mant_r[22:0]};
            flags.nx = round_bit || sticky;
        end
    end

    always_ff @(posedge clk) begin
        if (enable) begin
            result.value <= value;
            result.flags <= flags;
        end
    end

endmodule

//--- verilog/fpu_defs.svh
/*
 * Shared sizing macros of the FMA unit: lane count, PE count,
 * PE pipeline depth and request tag width
 */
`ifndef FPU_DEFS_SVH
`define FPU_DEFS_SVH

`define FMA_NUM_LANES 4
// Must divide the lane count
`define FMA_NUM_PES   2
`define FMA_LATENCY   3
`define FMA_TAG_WIDTH 4

`endif

//--- verilog/fpu_fma.sv
/*
 * Multi-lane fp32 FMA unit top level: operand select, lane
 * serializer with its PEs, and flag merge on plain ports
 */
`timescale 1ns/1ps
`include "fpu_defs.svh"

module fpu_fma (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            valid_in,
    output logic                            ready_in,
    input  logic [`FMA_NUM_LANES-1:0]       mask_in,
    input  logic [`FMA_TAG_WIDTH-1:0]       tag_in,
    input  logic                            is_madd,
    input  logic                            is_sub,
    input  logic                            is_neg,
    input  logic [`FMA_NUM_LANES-1:0][31:0] dataa,
    input  logic [`FMA_NUM_LANES-1:0][31:0] datab,
    input  logic [`FMA_NUM_LANES-1:0][31:0] datac,
    output logic                            valid_out,
    input  logic                            ready_out,
    output logic [`FMA_NUM_LANES-1:0][31:0] result,
    output fpu_pkg::fflags_t                fflags,
    output logic [`FMA_TAG_WIDTH-1:0]       tag_out
);
    import fpu_pkg::*;

    lane_stream_if #(.payload_t(fma_req_t)) req_s ();
    lane_stream_if #(.payload_t(fma_rsp_t)) rsp_s ();

    fma_operand_select fma_operand_select_i (
        .clk      (clk),
        .reset    (reset),
        .valid_in (valid_in),
        .ready_in (ready_in),
        .mask_in  (mask_in),
        .tag_in   (tag_in),
        .is_madd  (is_madd),
        .is_sub   (is_sub),
        .is_neg   (is_neg),
        .dataa    (dataa),
        .datab    (datab),
        .datac    (datac),
        .req_s    (req_s.source)
    );

    pe_serializer pe_serializer_i (
        .clk   (clk),
        .reset (reset),
        .req_s (req_s.sink),
        .rsp_s (rsp_s.source)
    );

    fflags_merge fflags_merge_i (
        .clk       (clk),
        .reset     (reset),
        .rsp_s     (rsp_s.sink),
        .valid_out (valid_out),
        .ready_out (ready_out),
        .result    (result),
        .fflags    (fflags),
        .tag_out   (tag_out)
    );

endmodule

//--- verilog/fpu_pkg.sv
/*
 * FMA unit types: exception flags, per-lane operands and results,
 * and the full-width request and response payloads
 */
`include "fpu_defs.svh"

package fpu_pkg;

    // NV, DZ, OF, UF, NX from msb to lsb
    typedef struct packed {
        logic nv;
        logic dz;
        logic of;
        logic uf;
        logic nx;
    } fflags_t;

    typedef struct packed {
        logic [31:0] c;
        logic [31:0] b;
        logic [31:0] a;
    } fma_operands_t;

    typedef struct packed {
        fflags_t     flags;
        logic [31:0] value;
    } lane_result_t;

    typedef fma_operands_t [`FMA_NUM_LANES-1:0] fma_req_t;
    typedef lane_result_t  [`FMA_NUM_LANES-1:0] fma_rsp_t;

endpackage

//--- verilog/lane_stream_if.sv
/*
 * Valid/ready lane stream with a typed payload, lane mask and tag,
 * plus source and sink modports
 */
`timescale 1ns/1ps
`include "fpu_defs.svh"

interface lane_stream_if #(
    parameter type payload_t = logic
);
    logic                      valid;
    logic                      ready;
    payload_t                  payload;
    logic [`FMA_NUM_LANES-1:0] mask;
    logic [`FMA_TAG_WIDTH-1:0] tag;

    modport source (output valid, output payload, output mask, output tag, input ready);

    modport sink (input valid, input payload, input mask, input tag, output ready);

endinterface

//--- verilog/pe_serializer.sv
/*
 * Lane serializer: feeds PE-sized batches of a request through the
 * FMA PEs, carries mask and tag alongside, rebuilds full result
 * vectors and queues them in a 2-entry output FIFO
 */
`timescale 1ns/1ps
`include "fpu_defs.svh"

module pe_serializer (
    input  logic          clk,
    input  logic          reset,
    lane_stream_if.sink   req_s,
    lane_stream_if.source rsp_s
);
    import fpu_pkg::*;

    localparam int LANES   = `FMA_NUM_LANES;
    localparam int PES     = `FMA_NUM_PES;
    localparam int BATCHES = LANES / PES;
    localparam int LAT     = `FMA_LATENCY;
    localparam int BW      = (BATCHES > 1) ? $clog2(BATCHES) : 1;

    typedef struct packed {
        fma_rsp_t                  data;
        logic [LANES-1:0]          mask;
        logic [`FMA_TAG_WIDTH-1:0] tag;
    } entry_t;

    logic                    pe_enable;
    logic                    issue;
    logic                    batch_last;
    logic [BW-1:0]           batch_idx;
    fma_operands_t [PES-1:0] pe_in;
    lane_result_t  [PES-1:0] pe_out;

    // Side band travelling next to the PE pipelines
    logic [LAT-1:0]                     dl_valid;
    logic [LAT-1:0][BW-1:0]             dl_batch;
    logic [LAT-1:0][LANES-1:0]          dl_mask;
    logic [LAT-1:0][`FMA_TAG_WIDTH-1:0] dl_tag;

    fma_rsp_t collect;
    fma_rsp_t assembled;
    entry_t   fifo_mem [2];
    logic     wr_ptr;
    logic     rd_ptr;
    logic [1:0] count;
    logic     full;
    logic     push;
    logic     pop;

    // Step only with work present and room for what may complete
    assign full       = count == 2'd2;
    assign pe_enable  = (req_s.valid || |dl_valid) && (!full || rsp_s.ready);
    assign issue      = req_s.valid && pe_enable;
    assign batch_last = batch_idx == BW'(BATCHES - 1);
    assign req_s.ready = pe_enable && batch_last;

    for (genvar p = 0; p < PES; p++) begin : g_pe
        assign pe_in[p] = req_s.payload[int'(batch_idx) * PES + p];

        fma_pe fma_pe_i (
            .clk      (clk),
            .enable   (pe_enable),
            .operands (pe_in[p]),
            .result   (pe_out[p])
        );
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            batch_idx <= '0;
            dl_valid  <= '0;
        end else if (pe_enable) begin
            if (issue) begin
                batch_idx <= batch_last ? '0 : batch_idx + 1'b1;
            end
            for (int s = LAT - 1; s > 0; s--) begin
                dl_valid[s] <= dl_valid[s-1];
            end
            dl_valid[0] <= issue;
        end
    end

    always_ff @(posedge clk) begin
        if (pe_enable) begin
            for (int s = LAT - 1; s > 0; s--) begin
                dl_batch[s] <= dl_batch[s-1];
                dl_mask[s]  <= dl_mask[s-1];
                dl_tag[s]   <= dl_tag[s-1];
            end
            dl_batch[0] <= batch_idx;
            dl_mask[0]  <= req_s.mask;
            dl_tag[0]   <= req_s.tag;
        end
    end

    // Merge the batch leaving the PEs into the partial result vector
    always_comb begin
        assembled = collect;
        for (int p = 0; p < PES; p++) begin
            assembled[int'(dl_batch[LAT-1]) * PES + p] = pe_out[p];
        end
    end

    always_ff @(posedge clk) begin
        if (pe_enable && dl_valid[LAT-1]) begin
            collect <= assembled;
        end
    end

    assign push = pe_enable && dl_valid[LAT-1] && dl_batch[LAT-1] == BW'(BATCHES - 1);
    assign pop  = rsp_s.valid && rsp_s.ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end else begin
            if (push) begin
                wr_ptr <= !wr_ptr;
            end
            if (pop) begin
                rd_ptr <= !rd_ptr;
            end
            count <= count + {1'b0, push} - {1'b0, pop};
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            fifo_mem[wr_ptr] <= '{data: assembled, mask: dl_mask[LAT-1], tag: dl_tag[LAT-1]};
        end
    end

    assign rsp_s.valid   = count != 2'd0;
    assign rsp_s.payload = fifo_mem[rd_ptr].data;
    assign rsp_s.mask    = fifo_mem[rd_ptr].mask;
    assign rsp_s.tag     = fifo_mem[rd_ptr].tag;

    a_fifo_no_overflow: assert property (@(posedge clk) disable iff (reset)
        push && !pop |-> !full);

endmodule
